//--- Bender.yml
package:
  name: noiseApu

export_include_dirs:
  - include

sources:
  - rtl/apuBusPkg.sv
  - rtl/apuFramePkg.sv
  - rtl/apuRegisters.sv
  - rtl/lengthTable.sv
  - rtl/frameSequencer.sv
  - rtl/noiseChannel.sv
  - rtl/noiseApuTop.sv
  - target: test
    files:
      - tests/noiseApuTb.sv

//--- include/noiseApu_params.svh
`ifndef NOISE_APU_PARAMS_SVH
`define NOISE_APU_PARAMS_SVH

// CPU bus
`define APU_ADDR_W 5
`define APU_DATA_W 8

// Number of ce ticks between sequencer steps
// Real hardware runs at 3729, the small value keeps simulation short
`define FRAME_STEP_TICKS 64

// Noise period timer width, wide enough for the longest period entry
`define NOISE_TIMER_W 12

// Length counter and its load value
`define LEN_W 8

`endif

//--- rtl/apuBusPkg.sv
package apuBusPkg;

  // CPU-side offsets inside the audio register window
  typedef enum logic [4:0] {
    NOISE_VOL    = 5'h0C,  // Loop, constant-volume and volume/divider period
    NOISE_PERIOD = 5'h0E,  // Short mode and period index
    NOISE_LEN    = 5'h0F,  // Length index, also restarts the envelope
    STATUS       = 5'h15,
    FRAME_CTRL   = 5'h17
  } apuReg;

  // 0x0D belongs to the noise block but has no function

endpackage

//--- rtl/apuFramePkg.sv
package apuFramePkg;

  typedef enum logic {
    MODE_4STEP = 1'b0,
    MODE_5STEP = 1'b1
  } frameMode;

  // STEP5 is only reached in 5-step mode
  typedef enum logic [2:0] {
    STEP1 = 3'd0,
    STEP2 = 3'd1,
    STEP3 = 3'd2,
    STEP4 = 3'd3,
    STEP5 = 3'd4
  } frameStep;

endpackage

//--- rtl/apuRegisters.sv
`timescale 1ns/1ps
`include "noiseApu_params.svh"

module apuRegisters import apuBusPkg::*, apuFramePkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ce,
  input  logic [`APU_ADDR_W-1:0] busAddr,
  input  logic [`APU_DATA_W-1:0] busWriteData,
  input  logic                   busWrite,
  input  logic                   isNonZero,
  output logic [`APU_DATA_W-1:0] busReadData,
  output logic [1:0]             chanAddr,
  output logic                   chanWrite,
  output logic [4:0]             lenIndex,
  output logic                   noiseEnabled,
  output frameMode               mode,
  output logic                   frameRestart
);

  apuReg regSel;
  logic  writeStrobe;

  assign regSel      = apuReg'(busAddr);
  assign writeStrobe = busWrite && ce;

  // Channel sees the low offset bits, the length index sits in the top five data bits
  assign chanAddr = busAddr[1:0];
  assign lenIndex = busWriteData[7:3];

  always_comb begin
    chanWrite    = 1'b0;
    frameRestart = 1'b0;
    case (regSel)
      NOISE_VOL, NOISE_PERIOD, NOISE_LEN: begin
        chanWrite = writeStrobe;
      end
      FRAME_CTRL: begin
        frameRestart = writeStrobe;  // Sequencer restarts on every frame-counter write
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      noiseEnabled <= 1'b0;
      mode         <= MODE_4STEP;
    end else if (writeStrobe) begin
      if (regSel == STATUS) begin
        noiseEnabled <= busWriteData[3];
      end
      if (regSel == FRAME_CTRL) begin
        mode <= frameMode'(busWriteData[7]);
      end
    end
  end

  // Status byte carries only the noise length flag
  always_comb begin
    busReadData = '0;
    if (regSel == STATUS) begin
      busReadData[3] = isNonZero;
    end
  end

endmodule

//--- rtl/frameSequencer.sv
`timescale 1ns/1ps
`include "noiseApu_params.svh"

module frameSequencer import apuFramePkg::*; (
  input  logic     clk,
  input  logic     reset,
  input  logic     ce,
  input  frameMode mode,
  input  logic     frameRestart,
  output logic     quarterFrame,
  output logic     halfFrame
);

  localparam int tickW = $clog2(`FRAME_STEP_TICKS);
  localparam logic [tickW-1:0] lastTick = tickW'(`FRAME_STEP_TICKS - 1);

  frameStep         step;
  frameStep         nextStep;
  logic [tickW-1:0] tickCount;
  logic             restartPending;  // A restart happened, 5-step mode fires on the next ce
  logic             stepDone;
  logic             restartFire;
  logic             stepQuarter;
  logic             stepHalf;

  assign stepDone    = ce && !frameRestart && (tickCount == lastTick);
  assign restartFire = ce && !frameRestart && restartPending && (mode == MODE_5STEP);

  // Which clocks the finishing step gives, and where the sequence goes next
  always_comb begin
    stepQuarter = 1'b1;
    stepHalf    = 1'b0;
    nextStep    = STEP1;
    case (step)
      STEP1: nextStep = STEP2;
      STEP2: begin
        nextStep = STEP3;
        stepHalf = 1'b1;
      end
      STEP3: nextStep = STEP4;
      STEP4: begin
        if (mode == MODE_5STEP) begin
          nextStep    = STEP5;
          stepQuarter = 1'b0;  // Silent step in 5-step mode
        end else begin
          stepHalf = 1'b1;
        end
      end
      STEP5: stepHalf = 1'b1;
      default: stepQuarter = 1'b0;
    endcase
  end

  assign quarterFrame = (stepDone && stepQuarter) || restartFire;
  assign halfFrame    = (stepDone && stepHalf) || restartFire;

  always_ff @(posedge clk) begin
    if (reset) begin
      step           <= STEP1;
      tickCount      <= '0;
      restartPending <= 1'b0;
    end else if (ce) begin
      if (frameRestart) begin
        step           <= STEP1;
        tickCount      <= '0;
        restartPending <= 1'b1;
      end else begin
        restartPending <= 1'b0;
        if (tickCount == lastTick) begin
          tickCount <= '0;
          step      <= nextStep;
        end else begin
          tickCount <= tickCount + 1'b1;
        end
      end
    end
  end

endmodule

//--- rtl/lengthTable.sv
`timescale 1ns/1ps
`include "noiseApu_params.svh"

module lengthTable (
  input  logic [4:0]        lenIndex,
  output logic [`LEN_W-1:0] lenLoad
);

  localparam int lenW = `LEN_W;

  // Odd indices give short fixed counts, even ones follow two note-length scales
  always_comb begin
    case (lenIndex)
      5'd0:    lenLoad = lenW'(10);
      5'd1:    lenLoad = lenW'(254);
      5'd2:    lenLoad = lenW'(20);
      5'd3:    lenLoad = lenW'(2);
      5'd4:    lenLoad = lenW'(40);
      5'd5:    lenLoad = lenW'(4);
      5'd6:    lenLoad = lenW'(80);
      5'd7:    lenLoad = lenW'(6);
      5'd8:    lenLoad = lenW'(160);
      5'd9:    lenLoad = lenW'(8);
      5'd10:   lenLoad = lenW'(60);
      5'd11:   lenLoad = lenW'(10);
      5'd12:   lenLoad = lenW'(14);
      5'd13:   lenLoad = lenW'(12);
      5'd14:   lenLoad = lenW'(26);
      5'd15:   lenLoad = lenW'(14);
      5'd16:   lenLoad = lenW'(12);
      5'd17:   lenLoad = lenW'(16);
      5'd18:   lenLoad = lenW'(24);
      5'd19:   lenLoad = lenW'(18);
      5'd20:   lenLoad = lenW'(48);
      5'd21:   lenLoad = lenW'(20);
      5'd22:   lenLoad = lenW'(96);
      5'd23:   lenLoad = lenW'(22);
      5'd24:   lenLoad = lenW'(192);
      5'd25:   lenLoad = lenW'(24);
      5'd26:   lenLoad = lenW'(72);
      5'd27:   lenLoad = lenW'(26);
      5'd28:   lenLoad = lenW'(16);
      5'd29:   lenLoad = lenW'(28);
      5'd30:   lenLoad = lenW'(32);
      default: lenLoad = lenW'(30);  // Index 31
    endcase
  end

endmodule

//--- rtl/noiseApuTop.sv
`timescale 1ns/1ps
`include "noiseApu_params.svh"

module noiseApuTop import apuFramePkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ce,
  input  logic [`APU_ADDR_W-1:0] busAddr,
  input  logic [`APU_DATA_W-1:0] busWriteData,
  input  logic                   busWrite,
  input  logic                   busRead,  // Reads have no side effect, so this stops here
  output logic [`APU_DATA_W-1:0] busReadData,
  output logic [3:0]             sample
);

  logic [1:0]        chanAddr;
  logic              chanWrite;
  logic [4:0]        lenIndex;
  logic [`LEN_W-1:0] lenLoad;
  logic              noiseEnabled;
  frameMode          mode;
  logic              frameRestart;
  logic              quarterFrame;
  logic              halfFrame;
  logic              isNonZero;

  apuRegisters registers_i (
    .clk(clk),
    .reset(reset),
    .ce(ce),
    .busAddr(busAddr),
    .busWriteData(busWriteData),
    .busWrite(busWrite),
    .isNonZero(isNonZero),
    .busReadData(busReadData),
    .chanAddr(chanAddr),
    .chanWrite(chanWrite),
    .lenIndex(lenIndex),
    .noiseEnabled(noiseEnabled),
    .mode(mode),
    .frameRestart(frameRestart)
  );

  lengthTable lengthTable_i (
    .lenIndex(lenIndex),
    .lenLoad(lenLoad)
  );

  frameSequencer frameSequencer_i (
    .clk(clk),
    .reset(reset),
    .ce(ce),
    .mode(mode),
    .frameRestart(frameRestart),
    .quarterFrame(quarterFrame),
    .halfFrame(halfFrame)
  );

  // Quarter frames clock the envelope, half frames the length counter
  noiseChannel noiseChannel_i (
    .clk(clk),
    .ce(ce),
    .reset(reset),
    .chanAddr(chanAddr),
    .chanWriteData(busWriteData),
    .chanWrite(chanWrite),
    .lenCtrClock(halfFrame),
    .envClock(quarterFrame),
    .enabled(noiseEnabled),
    .lenCtrIn(lenLoad),
    .sample(sample),
    .isNonZero(isNonZero)
  );

endmodule

//--- rtl/noiseChannel.sv
`timescale 1ns/1ps
`include "noiseApu_params.svh"

module noiseChannel (
  input  logic              clk,
  input  logic              ce,
  input  logic              reset,
  input  logic [1:0]        chanAddr,
  input  logic [7:0]        chanWriteData,
  input  logic              chanWrite,
  input  logic              lenCtrClock,
  input  logic              envClock,
  input  logic              enabled,
  input  logic [`LEN_W-1:0] lenCtrIn,
  output logic [3:0]        sample,
  output logic              isNonZero
);

  localparam int timerW = `NOISE_TIMER_W;

  logic              envLoop;
  logic              constVolume;
  logic              envRestart;   // Set by a length write, consumed by the next envelope clock
  logic [3:0]        volume;
  logic [3:0]        envelope;
  logic [3:0]        envDivider;
  logic [`LEN_W-1:0] lenCtr;
  logic              shortMode;
  logic [14:0]       lfsr;
  logic [3:0]        period;
  logic [timerW-1:0] noisePeriod;
  logic [timerW-1:0] timerCtr;
  logic              feedback;

  // Timer reload values in ce ticks
  always_comb begin
    case (period)
      4'd0:    noisePeriod = timerW'('h004);
      4'd1:    noisePeriod = timerW'('h008);
      4'd2:    noisePeriod = timerW'('h010);
      4'd3:    noisePeriod = timerW'('h020);
      4'd4:    noisePeriod = timerW'('h040);
      4'd5:    noisePeriod = timerW'('h060);
      4'd6:    noisePeriod = timerW'('h080);
      4'd7:    noisePeriod = timerW'('h0A0);
      4'd8:    noisePeriod = timerW'('h0CA);
      4'd9:    noisePeriod = timerW'('h0FE);
      4'd10:   noisePeriod = timerW'('h17C);
      4'd11:   noisePeriod = timerW'('h1FC);
      4'd12:   noisePeriod = timerW'('h2FA);
      4'd13:   noisePeriod = timerW'('h3F8);
      4'd14:   noisePeriod = timerW'('h7F2);
      default: noisePeriod = timerW'('hFE4);
    endcase
  end

  assign feedback = lfsr[0] ^ (shortMode ? lfsr[6] : lfsr[1]);  // Short mode gives the 93-step loop

  always_ff @(posedge clk) begin
    if (reset) begin
      envLoop     <= 1'b0;
      constVolume <= 1'b0;
      envRestart  <= 1'b0;
      volume      <= '0;
      envelope    <= '0;
      envDivider  <= '0;
      lenCtr      <= '0;
      shortMode   <= 1'b0;
      lfsr        <= 15'd1;
      period      <= '0;
      timerCtr    <= '0;
    end else if (ce) begin
      if (chanWrite) begin
        case (chanAddr)
          2'd0: begin
            envLoop     <= chanWriteData[5];
            constVolume <= chanWriteData[4];
            volume      <= chanWriteData[3:0];
          end
          2'd2: begin
            shortMode <= chanWriteData[7];
            period    <= chanWriteData[3:0];
          end
          2'd3: begin
            lenCtr     <= lenCtrIn;
            envRestart <= 1'b1;
          end
          default: begin
          end
        endcase
      end

      if (timerCtr == '0) begin
        timerCtr <= noisePeriod;
        lfsr     <= {feedback, lfsr[14:1]};
      end else begin
        timerCtr <= timerCtr - 1'b1;
      end

      // Loop bit doubles as the length halt
      if (lenCtrClock && lenCtr != '0 && !envLoop) begin
        lenCtr <= lenCtr - 1'b1;
      end

      if (envClock) begin
        if (envRestart) begin
          envDivider <= volume;
          envelope   <= 4'd15;
          envRestart <= 1'b0;
        end else if (envDivider == '0) begin
          envDivider <= volume;
          if (envelope != '0) begin
            envelope <= envelope - 1'b1;
          end else if (envLoop) begin
            envelope <= 4'd15;
          end
        end else begin
          envDivider <= envDivider - 1'b1;
        end
      end

      if (!enabled) begin
        lenCtr <= '0;  // Disable wins over a load or a decrement
      end
    end
  end

  assign isNonZero = (lenCtr != '0);
  assign sample    = (lenCtr == '0 || lfsr[0]) ? 4'd0 : (constVolume ? volume : envelope);

endmodule

//--- sources.f
+incdir+include
rtl/apuBusPkg.sv
rtl/apuFramePkg.sv
rtl/apuRegisters.sv
rtl/lengthTable.sv
rtl/frameSequencer.sv
rtl/noiseChannel.sv
rtl/noiseApuTop.sv
tests/noiseApuTb.sv

//--- tests/noiseApuTb.sv
`timescale 1ns/1ps
`include "noiseApu_params.svh"

module noiseApuTb import apuBusPkg::*; ();

  localparam int stepTicks = `FRAME_STEP_TICKS;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   ce;
  logic [`APU_ADDR_W-1:0] busAddr;
  logic [`APU_DATA_W-1:0] busWriteData;
  logic                   busWrite;
  logic                   busRead;
  logic [`APU_DATA_W-1:0] busReadData;
  logic [3:0]             sample;

  logic [31:0] rngState = 32'd85;
  logic        holdCe;  // Forces ce high around disable writes
  int          ceTicks;
  int          errors;
  int          lenRef [32];

  noiseApuTop dut_i (
    .clk(clk),
    .reset(reset),
    .ce(ce),
    .busAddr(busAddr),
    .busWriteData(busWriteData),
    .busWrite(busWrite),
    .busRead(busRead),
    .busReadData(busReadData),
    .sample(sample)
  );

  always #5 clk = ~clk;

  // A channel whose length flag reads 0 is silent
  assert property (@(posedge clk) disable iff (reset)
      (busAddr == STATUS && !busReadData[3]) |-> sample == 4'd0)
    else begin
      $display("MISMATCH at %0t: sample expected 0 actual %0d", $time, $sampled(sample));
      errors++;
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic drawRandom(output logic [31:0] r);
    rngState = xorshift32(rngState);
    r = rngState;
  endtask

  // Counts the ce tick taken at this edge, then draws ce for the next one
  task automatic nextCycle();
    logic [31:0] r;
    @(posedge clk);
    if (ce) ceTicks++;
    drawRandom(r);
    ce       <= holdCe || (r[1:0] != 2'b00);
    busWrite <= 1'b0;
    busRead  <= 1'b1;
  endtask

  task automatic busWriteReg(input apuReg addr, input logic [7:0] data);
    nextCycle();
    ce           <= 1'b1;
    busAddr      <= addr;
    busWriteData <= data;
    busWrite     <= 1'b1;
    busRead      <= 1'b0;
    nextCycle();  // The write lands on this edge
    busAddr <= STATUS;
  endtask

  task automatic readStatus(output logic [7:0] st);
    @(negedge clk);
    st = busReadData;
    assert ((st & 8'hF7) == 8'h00)
      else begin
        $display("MISMATCH at %0t: busReadData bits other than 3 expected 00 actual %02h",
                 $time, st & 8'hF7);
        errors++;
      end
  endtask

  task automatic checkValue(input string name, input int expected, input int actual);
    assert (expected == actual)
      else begin
        $display("MISMATCH at %0t: %s expected %0d actual %0d", $time, name, expected, actual);
        errors++;
      end
  endtask

  // Picks a random index whose table entry lies in lo..hi or else falls back to the given one
  task automatic pickIndex(input int lo, input int hi, input logic [4:0] fallback,
                           output logic [4:0] idx);
    logic [31:0] r;
    drawRandom(r);
    idx = r[4:0];
    if (lenRef[idx] < lo || lenRef[idx] > hi) idx = fallback;
  endtask

  task automatic waitStatusClear(input string what, input int limit, output int ticks);
    logic [7:0] st;
    int         start;
    int         cycles;
    start  = ceTicks;
    cycles = 0;
    readStatus(st);
    while (st[3] && cycles < limit) begin
      nextCycle();
      cycles++;
      readStatus(st);
    end
    ticks = ceTicks - start;
    if (st[3]) begin
      $display("Timeout: length flag never cleared during %s", what);
      errors++;
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [7:0]  st;
    logic [4:0]  idx;
    logic [3:0]  vol;
    int          len;
    int          ticks;
    int          cycles;
    int          start;
    int          limit;
    int          lastLevel;
    bit          sawZero;
    bit          sawVol;

    lenRef = '{10, 254, 20, 2, 40, 4, 80, 6, 160, 8, 60, 10, 14, 12, 26, 14,
               12, 16, 24, 18, 48, 20, 96, 22, 192, 24, 72, 26, 16, 28, 32, 30};
    reset        = 1'b1;
    ce           = 1'b0;
    busAddr      = STATUS;
    busWriteData = '0;
    busWrite     = 1'b0;
    busRead      = 1'b0;
    holdCe       = 1'b0;
    ceTicks      = 0;
    errors       = 0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    readStatus(st);
    checkValue("busReadData", 0, st);
    checkValue("sample", 0, sample);

    // Load, then disable and load while disabled
    busWriteReg(STATUS, 8'h08);
    busWriteReg(NOISE_VOL, 8'h00);
    pickIndex(0, 255, 5'd1, idx);
    busWriteReg(NOISE_LEN, {idx, 3'b000});
    readStatus(st);
    checkValue("status length flag", lenRef[idx] != 0, st[3]);
    holdCe = 1'b1;
    busWriteReg(STATUS, 8'h00);
    waitStatusClear("disable", 2, ticks);
    for (cycles = 0; cycles < 32; cycles++) begin
      nextCycle();
      @(negedge clk);
      checkValue("sample", 0, sample);
    end
    holdCe = 1'b0;
    busWriteReg(NOISE_LEN, {idx, 3'b000});
    readStatus(st);
    checkValue("status length flag", 0, st[3]);

    busWriteReg(STATUS, 8'h08);
    drawRandom(r);
    vol = (r[3:0] == 4'd0) ? 4'd9 : r[3:0];
    busWriteReg(NOISE_VOL, {4'b0001, vol});
    busWriteReg(NOISE_PERIOD, {r[8], 5'b00000, r[5:4]});  // Short periods keep the LFSR busy
    pickIndex(40, 255, 5'd1, idx);
    busWriteReg(NOISE_LEN, {idx, 3'b000});
    sawZero = 1'b0;
    sawVol  = 1'b0;
    cycles  = 0;
    readStatus(st);
    while (st[3] && cycles < 60000) begin
      assert (sample == 4'd0 || sample == vol)
        else begin
          $display("MISMATCH at %0t: sample expected 0 or %0d actual %0d", $time, vol, sample);
          errors++;
        end
      if (sample == 4'd0) sawZero = 1'b1;
      if (sample == vol) sawVol = 1'b1;
      nextCycle();
      cycles++;
      readStatus(st);
    end
    if (st[3]) begin
      $display("Timeout: constant-volume note never ended");
      errors++;
    end
    assert (sawZero && sawVol)
      else begin
        $display("Constant volume: sample did not show both 0 and volume %0d", vol);
        errors++;
      end

    // Half frames at steps 2 and 4 after the restart
    busWriteReg(NOISE_VOL, 8'h10);
    busWriteReg(FRAME_CTRL, 8'h00);
    pickIndex(2, 30, 5'd3, idx);
    len = lenRef[idx];
    busWriteReg(NOISE_LEN, {idx, 3'b000});
    waitStatusClear("4-step countdown", (2 * len + 2) * stepTicks * 4, ticks);
    assert (ticks >= (2 * len - 1) * stepTicks && ticks <= (2 * len + 1) * stepTicks)
      else begin
        $display("Length countdown took %0d ce ticks, expected %0d to %0d", ticks,
                 (2 * len - 1) * stepTicks, (2 * len + 1) * stepTicks);
        errors++;
      end

    busWriteReg(NOISE_VOL, 8'h30);
    busWriteReg(FRAME_CTRL, 8'h00);
    pickIndex(2, 30, 5'd3, idx);
    len = lenRef[idx];
    busWriteReg(NOISE_LEN, {idx, 3'b000});
    start  = ceTicks;
    limit  = (2 * len + 2) * stepTicks;
    cycles = 0;
    readStatus(st);
    while (ceTicks - start < limit && cycles < limit * 4) begin
      assert (st[3])
        else begin
          $display("Length counter ran out at %0t while halted by the loop bit", $time);
          errors++;
        end
      nextCycle();
      cycles++;
      readStatus(st);
    end
    if (ceTicks - start < limit) begin
      $display("Timeout: halt window did not finish");
      errors++;
    end
    busWriteReg(NOISE_VOL, 8'h10);
    busWriteReg(FRAME_CTRL, 8'h80);  // Switching to 5-step mode fires a half frame right away
    limit = ((len + 1) / 2) * 5 * stepTicks + stepTicks;
    waitStatusClear("5-step countdown", limit * 4, ticks);
    assert (ticks <= limit)
      else begin
        $display("Length counter took %0d ce ticks in 5-step mode, limit %0d", ticks, limit);
        errors++;
      end

    // Divider period 0 means one envelope step per quarter frame
    busWriteReg(NOISE_VOL, 8'h00);
    busWriteReg(FRAME_CTRL, 8'h00);
    start = ceTicks;
    pickIndex(20, 255, 5'd1, idx);
    busWriteReg(NOISE_LEN, {idx, 3'b000});
    lastLevel = 15;
    cycles    = 0;
    readStatus(st);
    while (ceTicks - start < 16 * stepTicks + 32 && cycles < 16 * stepTicks * 4) begin
      if (ceTicks - start >= stepTicks && sample != 4'd0) begin
        assert (sample <= lastLevel)
          else begin
            $display("MISMATCH at %0t: sample expected at most %0d actual %0d", $time,
                     lastLevel, sample);
            errors++;
          end
        lastLevel = sample;
      end
      if (ceTicks - start >= 16 * stepTicks) begin
        checkValue("sample", 0, sample);
        checkValue("status length flag", 1, st[3]);
      end
      nextCycle();
      cycles++;
      readStatus(st);
    end
    if (ceTicks - start < 16 * stepTicks + 32) begin
      $display("Timeout: envelope decay window did not finish");
      errors++;
    end

    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule
